// ==== sources.f ====
design/bpmPkg.sv
design/loPhase.sv
design/demodAccumulator.sv
design/magnitudeEngine.sv
design/bpmConfig.sv
design/bpmFrontEnd.sv
testbench/bpmChecker.sv
testbench/bpmFrontEndTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -j 0
TOP       ?= bpmFrontEndTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJDIR)

// ==== testbench/bpmFrontEndTb.sv ====
/* BPM front end testbench
   clock, reset, ADC stimulus, host credits, register access and reference */
module bpmFrontEndTb;
    import bpmPkg::*;

    typedef logic [SamplesPerTurn-1:0][NumChannels-1:0][AdcWidth-1:0] turnSamples_t;

    // LO reference, 2047 * cos/sin of k * 45 degrees
    localparam int CosRef [SamplesPerTurn] = '{2047, 1447, 0, -1447, -2047, -1447, 0, 1447};
    localparam int SinRef [SamplesPerTurn] = '{0, 1447, 2047, 1447, 0, -1447, -2047, -1447};

    logic                                     clk;
    logic                                     rstN;
    logic [NumChannels-1:0][AdcWidth-1:0]     adcSamples;
    logic                                     cfgStrobe;
    cfgAddr_e                                 cfgAddr;
    logic [CfgDataWidth-1:0]                  cfgWriteData;
    logic [CfgDataWidth-1:0]                  cfgReadData;
    logic                                     hostCredit;
    logic                                     magValid;
    magResult_t                               magOut;
    logic [MagWidth-1:0]                      expectedMag;
    logic                                     strictTags;
    logic                                     testEnd;
    int                                       testNum;
    int                                       sideErrors;
    int                                       resultCount;
    int                                       errorCount;

    turnSamples_t            turnLog [256];
    logic                    rmsLog [256];
    logic [SumShiftWidth-1:0] shiftLog [256];
    logic                    shadowRms;
    logic [SumShiftWidth-1:0] shadowShift;
    int                      sampleCount;
    int                      turnIdx;
    int                      phaseIdx;
    int                      owed;
    int                      returned;
    logic                    returnCredits;
    logic                    fullScale;

    bpmFrontEnd dut0 (
        .clk          (clk),
        .rstN         (rstN),
        .adcSamples   (adcSamples),
        .cfgStrobe    (cfgStrobe),
        .cfgAddr      (cfgAddr),
        .cfgWriteData (cfgWriteData),
        .cfgReadData  (cfgReadData),
        .hostCredit   (hostCredit),
        .magValid     (magValid),
        .mag          (magOut)
    );

    bpmChecker checker0 (
        .clk         (clk),
        .rstN        (rstN),
        .magValid    (magValid),
        .mag         (magOut),
        .expectedMag (expectedMag),
        .strictTags  (strictTags),
        .testEnd     (testEnd),
        .testNum     (testNum),
        .sideErrors  (sideErrors),
        .resultCount (resultCount),
        .errorCount  (errorCount)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // reference model
    function automatic logic [MagWidth-1:0] refMagnitude(input turnSamples_t s,
            input int ch, input logic useRms, input int shift);
        longint sumI;
        longint sumQ;
        longint x;
        longint m;
        longint limit;
        longint absI;
        longint absQ;
        longint est;
        sumI  = 0;
        sumQ  = 0;
        limit = (longint'(1) << (MagWidth - 1)) - 1;
        for (int k = 0; k < SamplesPerTurn; k++) begin
            x = longint'($signed(s[k][ch]));
            if (useRms) begin
                // square against the sample's upper 12 bits
                m = x >>> (AdcWidth - LoWidth);
                if (m < -2047) begin
                    m = -2047;
                end
                sumI = sumI + x * m;
            end else begin
                sumI = sumI + x * longint'(CosRef[k]);
                sumQ = sumQ + x * longint'(SinRef[k]);
            end
        end
        sumI = sumI >>> shift;
        sumQ = sumQ >>> shift;
        sumI = (sumI > limit) ? limit : ((sumI < -limit - 1) ? -limit - 1 : sumI);
        sumQ = (sumQ > limit) ? limit : ((sumQ < -limit - 1) ? -limit - 1 : sumQ);
        absI = (sumI < 0) ? -sumI : sumI;
        absQ = (sumQ < 0) ? -sumQ : sumQ;
        est = (absI > absQ) ? absI + (absQ >> 1) : absQ + (absI >> 1);
        if (est > limit) begin
            est = limit;
        end
        return MagWidth'(est);
    endfunction

    always_comb begin
        expectedMag = refMagnitude(turnLog[magOut.tag], int'(magOut.channel),
                                   rmsLog[magOut.tag], int'(shiftLog[magOut.tag]));
    end

    //////////////////////////////////////////////////
    // sample log, control shadow and host credit ledger
    always @(posedge clk) begin
        if (rstN) begin
            turnIdx  = (sampleCount / SamplesPerTurn) % 256;
            phaseIdx = sampleCount % SamplesPerTurn;
            turnLog[turnIdx][phaseIdx] = adcSamples;
            // control in effect at the first sample of the turn
            if (phaseIdx == 0) begin
                rmsLog[turnIdx]   = shadowRms;
                shiftLog[turnIdx] = shadowShift;
            end
            sampleCount = sampleCount + 1;
            owed = owed + int'(magValid) - int'(hostCredit);
            returned = returned + int'(hostCredit);
        end
        if (cfgStrobe && cfgAddr == CfgControl) begin
            shadowRms   = cfgWriteData[SumShiftWidth];
            shadowShift = cfgWriteData[SumShiftWidth-1:0];
        end
    end

    always @(negedge clk) begin
        for (int ch = 0; ch < NumChannels; ch++) begin
            adcSamples[ch] = fullScale ? 16'h7fff : AdcWidth'($urandom);
        end
        hostCredit = rstN && returnCredits && (owed > 0);
    end

    //////////////////////////////////////////////////
    // helpers
    task automatic waitCycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic waitResults(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (resultCount < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("timeout: %0d of %0d results arrived", resultCount, target);
                $display("RESULT: FAIL");
                $finish;
            end
        end
    endtask

    task automatic writeReg(input cfgAddr_e addr, input logic [CfgDataWidth-1:0] data);
        @(negedge clk);
        cfgStrobe    = 1'b1;
        cfgAddr      = addr;
        cfgWriteData = data;
        @(negedge clk);
        cfgStrobe = 1'b0;
    endtask

    task automatic readReg(input cfgAddr_e addr, output logic [CfgDataWidth-1:0] data);
        @(negedge clk);
        cfgAddr = addr;
        @(posedge clk);
        data = cfgReadData;
    endtask

    task automatic writeControl(input logic useRms, input int shift);
        writeReg(CfgControl, CfgDataWidth'({useRms, SumShiftWidth'(shift)}));
    endtask

    task automatic expectReg(input cfgAddr_e addr, input logic nonzero, input string what);
        logic [CfgDataWidth-1:0] value;
        readReg(addr, value);
        if ((value != '0) != nonzero) begin
            $display("[ERROR] %0t %s read %0d", $time, what, value);
            sideErrors++;
        end
    endtask

    task automatic finishTest;
        @(negedge clk);
        testEnd = 1'b1;
        @(negedge clk);
        testEnd = 1'b0;
        testNum++;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    initial begin
        int resStart;
        int retStart;
        clk           = 1'b0;
        rstN          = 1'b0;
        adcSamples    = '0;
        cfgStrobe     = 1'b0;
        cfgAddr       = CfgControl;
        cfgWriteData  = '0;
        hostCredit    = 1'b0;
        strictTags    = 1'b1;
        testEnd       = 1'b0;
        testNum       = 1;
        sideErrors    = 0;
        shadowRms     = 1'b0;
        shadowShift   = '0;
        sampleCount   = 0;
        owed          = 0;
        returned      = 0;
        returnCredits = 1'b1;
        fullScale     = 1'b0;
        void'($urandom(32'h63a25c33));
        repeat (2) @(negedge clk);
        rstN = 1'b1;

        writeControl(1'b0, 4);
        waitResults(resultCount + 40, 200);
        finishTest();

        writeControl(1'b1, 10);
        waitResults(resultCount + 40, 200);
        finishTest();

        // full scale squares overflow with no shift
        fullScale = 1'b1;
        writeControl(1'b1, 0);
        waitCycles(24);
        waitResults(resultCount + 12, 100);
        expectReg(CfgStatus, 1'b1, "overflow status after saturation");
        fullScale = 1'b0;
        writeControl(1'b1, 10);
        waitCycles(24);
        expectReg(CfgStatus, 1'b1, "sticky overflow before clear");
        writeReg(CfgStatus, 32'd1);
        waitCycles(2);
        expectReg(CfgStatus, 1'b0, "overflow status after clear");
        finishTest();

        strictTags = 1'b0;
        writeControl(1'b0, 4);
        returnCredits = 1'b0;
        resStart = resultCount;
        retStart = returned;
        waitCycles(40);
        if (resultCount - resStart > HostCredits + (returned - retStart)) begin
            $display("[ERROR] %0t %0d results with %0d credits returned", $time,
                     resultCount - resStart, returned - retStart);
            sideErrors++;
        end
        expectReg(CfgDropCount, 1'b1, "drop count after withheld credits");
        returnCredits = 1'b1;
        waitResults(resultCount + 8, 100);
        finishTest();

        waitCycles(32);
        writeReg(CfgDropCount, '0);
        strictTags = 1'b1;
        waitCycles(80);
        expectReg(CfgDropCount, 1'b0, "drop count over recovery");
        waitResults(resultCount + 4, 50);
        finishTest();

        $display("results %0d, checker errors %0d, other errors %0d",
                 resultCount, errorCount, sideErrors);
        if (errorCount == 0 && sideErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/bpmChecker.sv ====
/* Result checker
   watches the magnitude stream, compares it with the testbench reference
   and keeps per-test and overall tallies */
module bpmChecker (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        magValid,
    input  bpmPkg::magResult_t          mag,
    input  logic [bpmPkg::MagWidth-1:0] expectedMag,
    input  logic                        strictTags,
    input  logic                        testEnd,
    input  int                          testNum,
    input  int                          sideErrors,
    output int                          resultCount,
    output int                          errorCount
);
    import bpmPkg::*;

    int   expChannel;
    int   lastTag;
    logic haveTag;
    int   testResults;
    int   errStart;
    int   sideStart;
    int   tag;
    int   testErrs;

    function automatic string testName(input int num);
        case (num)
            1:       return "IQ mode";
            2:       return "RMS mode";
            3:       return "saturation";
            4:       return "back-pressure";
            5:       return "recovery";
            default: return "unnamed";
        endcase
    endfunction

    initial begin
        resultCount = 0;
        errorCount  = 0;
        expChannel  = 0;
        lastTag     = 0;
        haveTag     = 1'b0;
        testResults = 0;
        errStart    = 0;
        sideStart   = 0;
    end

    //////////////////////////////////////////////////
    // per-result comparison
    always @(posedge clk) begin
        if (rstN && magValid) begin
            resultCount = resultCount + 1;
            testResults = testResults + 1;
            tag = int'(mag.tag);
            if (int'(mag.channel) != expChannel) begin
                $display("[ERROR] %0t channel %0d out of order, expected %0d",
                         $time, mag.channel, expChannel);
                errorCount = errorCount + 1;
            end
            if (mag.channel == '0) begin
                // new turn, tags must move forward
                if (haveTag && (strictTags ? (tag != lastTag + 1) : (tag <= lastTag))) begin
                    $display("[ERROR] %0t tag %0d after tag %0d", $time, tag, lastTag);
                    errorCount = errorCount + 1;
                end
                haveTag = 1'b1;
                lastTag = tag;
            end else if (tag != lastTag) begin
                $display("[ERROR] %0t tag %0d changed inside turn %0d", $time, tag, lastTag);
                errorCount = errorCount + 1;
            end
            if (mag.mag != expectedMag) begin
                $display("[ERROR] %0t tag %0d ch %0d magnitude %0d, expected %0d",
                         $time, tag, mag.channel, mag.mag, expectedMag);
                errorCount = errorCount + 1;
            end
            expChannel = (int'(mag.channel) + 1) % NumChannels;
        end
        if (testEnd) begin
            testErrs = (errorCount - errStart) + (sideErrors - sideStart);
            $display("test %0d %s: %0d results, %0d errors, %s", testNum,
                     testName(testNum), testResults, testErrs,
                     (testErrs == 0) ? "ok" : "failed");
            testResults = 0;
            errStart    = errorCount;
            sideStart   = sideErrors;
        end
    end

endmodule

// ==== design/bpmFrontEnd.sv ====
/* BPM front end top level
   LO, demodulator/accumulator, magnitude engine and register block */
module bpmFrontEnd (
    input  logic                                               clk,
    input  logic                                               rstN,
    input  logic signed [bpmPkg::NumChannels-1:0][bpmPkg::AdcWidth-1:0] adcSamples,
    input  logic                                               cfgStrobe,
    input  bpmPkg::cfgAddr_e                                   cfgAddr,
    input  logic [bpmPkg::CfgDataWidth-1:0]                    cfgWriteData,
    output logic [bpmPkg::CfgDataWidth-1:0]                    cfgReadData,
    input  logic                                               hostCredit,
    output logic                                               magValid,
    output bpmPkg::magResult_t                                 mag
);
    import bpmPkg::*;

    logic signed [LoWidth-1:0] loCos;
    logic signed [LoWidth-1:0] loSin;
    logic                      turnEnd;
    cfgControl_t               control;
    logic                      frameValid;
    sumFrame_t                 frame;
    logic                      frameCredit;
    logic                      overflowPulse;
    logic                      dropPulse;

    loPhase loPhase0 (
        .clk     (clk),
        .rstN    (rstN),
        .phase   (),
        .loCos   (loCos),
        .loSin   (loSin),
        .turnEnd (turnEnd)
    );

    demodAccumulator demod0 (
        .clk           (clk),
        .rstN          (rstN),
        .adcSamples    (adcSamples),
        .loCos         (loCos),
        .loSin         (loSin),
        .turnEnd       (turnEnd),
        .control       (control),
        .frameCredit   (frameCredit),
        .frameValid    (frameValid),
        .frame         (frame),
        .overflowPulse (overflowPulse),
        .dropPulse     (dropPulse)
    );

    magnitudeEngine engine0 (
        .clk         (clk),
        .rstN        (rstN),
        .frameValid  (frameValid),
        .frame       (frame),
        .frameCredit (frameCredit),
        .hostCredit  (hostCredit),
        .magValid    (magValid),
        .mag         (mag)
    );

    bpmConfig config0 (
        .clk           (clk),
        .rstN          (rstN),
        .cfgStrobe     (cfgStrobe),
        .cfgAddr       (cfgAddr),
        .cfgWriteData  (cfgWriteData),
        .cfgReadData   (cfgReadData),
        .control       (control),
        .overflowPulse (overflowPulse),
        .dropPulse     (dropPulse)
    );

endmodule

// ==== design/bpmConfig.sv ====
/* Configuration registers
   control word, sticky overflow status and saturating drop counter */
module bpmConfig (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             cfgStrobe,
    input  bpmPkg::cfgAddr_e                 cfgAddr,
    input  logic [bpmPkg::CfgDataWidth-1:0]  cfgWriteData,
    output logic [bpmPkg::CfgDataWidth-1:0]  cfgReadData,
    output bpmPkg::cfgControl_t              control,
    input  logic                             overflowPulse,
    input  logic                             dropPulse
);
    import bpmPkg::*;

    logic                      overflowSticky;
    logic [DropCountWidth-1:0] dropCount;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            control        <= '0;
            overflowSticky <= 1'b0;
            dropCount      <= '0;
        end else begin
            if (cfgStrobe && cfgAddr == CfgControl) begin
                control <= cfgWriteData[$bits(cfgControl_t)-1:0];
            end
            // a new overflow wins over a clear in the same cycle
            if (overflowPulse) begin
                overflowSticky <= 1'b1;
            end else if (cfgStrobe && cfgAddr == CfgStatus && cfgWriteData[0]) begin
                overflowSticky <= 1'b0;
            end
            if (cfgStrobe && cfgAddr == CfgDropCount) begin
                dropCount <= '0;
            end else if (dropPulse && dropCount != '1) begin
                dropCount <= dropCount + 1'b1;
            end
        end
    end

    // readback
    always_comb begin
        case (cfgAddr)
            CfgControl:   cfgReadData = CfgDataWidth'(control);
            CfgStatus:    cfgReadData = CfgDataWidth'(overflowSticky);
            CfgDropCount: cfgReadData = CfgDataWidth'(dropCount);
            default:      cfgReadData = '0;
        endcase
    end

endmodule

// ==== design/magnitudeEngine.sv ====
/* Shared magnitude engine
   buffers two frames and serves the four channels in turn as max + min/2,
   one result per host credit */
module magnitudeEngine (
    input  logic               clk,
    input  logic               rstN,
    input  logic               frameValid,
    input  bpmPkg::sumFrame_t  frame,
    output logic               frameCredit,
    input  logic               hostCredit,
    output logic               magValid,
    output bpmPkg::magResult_t mag
);
    import bpmPkg::*;

    engineState_e                state;
    sumFrame_t                   slots [EngineCredits];
    logic [SlotPtrWidth-1:0]     wrPtr;
    logic [SlotPtrWidth-1:0]     rdPtr;
    logic [EngineCreditWidth-1:0] used;
    logic [HostCreditWidth-1:0]  hostCount;
    logic [ChannelWidth-1:0]     channel;
    logic                        pop;
    iqPair_t                     pair;
    logic [MagWidth-1:0]         absI;
    logic [MagWidth-1:0]         absQ;
    logic [MagWidth-1:0]         larger;
    logic [MagWidth-1:0]         smaller;
    logic [MagWidth:0]           estimate;

    //////////////////////////////////////////////////
    // frame slots
    always_ff @(posedge clk) begin
        if (frameValid) begin
            slots[wrPtr] <= frame;
        end
    end

    //////////////////////////////////////////////////
    // magnitude of the current channel
    always_comb begin
        pair = slots[rdPtr].iq[channel];
        absI = pair.i[MagWidth-1] ? -pair.i : pair.i;
        absQ = pair.q[MagWidth-1] ? -pair.q : pair.q;
        larger = (absI > absQ) ? absI : absQ;
        smaller = (absI > absQ) ? absQ : absI;
        estimate = {1'b0, larger} + {2'b00, smaller[MagWidth-1:1]};
        mag.tag = slots[rdPtr].tag;
        mag.channel = channel;
        mag.mag = (estimate > {1'b0, MagMax}) ? MagMax : estimate[MagWidth-1:0];
    end

    // stall while the host holds all credits
    assign magValid = (state == Serve) && (hostCount != '0);
    assign pop = magValid && (channel == ChannelWidth'(NumChannels - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state       <= Idle;
            wrPtr       <= '0;
            rdPtr       <= '0;
            used        <= '0;
            hostCount   <= HostCreditWidth'(HostCredits);
            channel     <= '0;
            frameCredit <= 1'b0;
        end else begin
            if (frameValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            used <= used + EngineCreditWidth'(frameValid) - EngineCreditWidth'(pop);
            hostCount <= hostCount + HostCreditWidth'(hostCredit)
                       - HostCreditWidth'(magValid);
            if (magValid) begin
                channel <= channel + 1'b1;
            end
            // slot freed after channel 3 goes out
            frameCredit <= pop;
            case (state)
                Idle: begin
                    if (frameValid) begin
                        state <= Serve;
                    end
                end
                Serve: begin
                    if (pop && used == EngineCreditWidth'(1) && !frameValid) begin
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // host credits never wrap below zero or above the grant
    hostBound: assert property (@(posedge clk) disable iff (!rstN)
        hostCount <= HostCreditWidth'(HostCredits));

    // results only come from a buffered frame
    serveHasFrame: assert property (@(posedge clk) disable iff (!rstN)
        magValid |-> (used != '0));

endmodule

// ==== design/demodAccumulator.sv ====
/* Demodulator and turn accumulator
   mixes each channel against the LO (or squares it), sums a turn, then
   shifts, saturates and issues the frame under engine credits */
module demodAccumulator (
    input  logic                                               clk,
    input  logic                                               rstN,
    input  logic signed [bpmPkg::NumChannels-1:0][bpmPkg::AdcWidth-1:0] adcSamples,
    input  logic signed [bpmPkg::LoWidth-1:0]                  loCos,
    input  logic signed [bpmPkg::LoWidth-1:0]                  loSin,
    input  logic                                               turnEnd,
    input  bpmPkg::cfgControl_t                                control,
    input  logic                                               frameCredit,
    output logic                                               frameValid,
    output bpmPkg::sumFrame_t                                  frame,
    output logic                                               overflowPulse,
    output logic                                               dropPulse
);
    import bpmPkg::*;

    logic                          turnStart;
    cfgControl_t                   activeControl;
    cfgControl_t                   effControl;
    logic [EngineCreditWidth-1:0]  credits;
    logic [TurnTagWidth-1:0]       turnTag;
    logic                          issue;
    iqPair_t [NumChannels-1:0]     turnIq;
    logic [NumChannels-1:0]        satFlags;

    // returns {saturated, value}
    function automatic logic [MagWidth:0] shiftSaturate(
        input logic signed [SumWidth-1:0] total,
        input logic [SumShiftWidth-1:0]   shift
    );
        logic signed [SumWidth-1:0] shifted;
        shifted = total >>> shift;
        if (shifted > SumWidth'(MagMax)) begin
            return {1'b1, MagMax};
        end else if (shifted < SumWidth'(MagMin)) begin
            return {1'b1, MagMin};
        end
        return {1'b0, shifted[MagWidth-1:0]};
    endfunction

    // mode is fixed for the whole turn from its first sample
    assign effControl = turnStart ? control : activeControl;

    //////////////////////////////////////////////////
    // per-channel mixer and accumulator
    for (genvar ch = 0; ch < NumChannels; ch++) begin : gChannel
        logic signed [LoWidth-1:0]      rmsUpper;
        logic signed [LoWidth-1:0]      rmsMult;
        logic signed [LoWidth-1:0]      cosMult;
        logic signed [LoWidth-1:0]      sinMult;
        logic signed [ProductWidth-1:0] sampleWide;
        logic signed [ProductWidth-1:0] prodI;
        logic signed [ProductWidth-1:0] prodQ;
        logic signed [SumWidth-1:0]     sumI;
        logic signed [SumWidth-1:0]     sumQ;
        logic signed [SumWidth-1:0]     totalI;
        logic signed [SumWidth-1:0]     totalQ;
        logic [MagWidth:0]              satI;
        logic [MagWidth:0]              satQ;

        always_comb begin
            sampleWide = ProductWidth'($signed(adcSamples[ch]));
            // RMS multiplier is the sample's upper LoWidth bits,
            // kept inside the LO range so the square fits the product
            rmsUpper = $signed(adcSamples[ch][AdcWidth-1 -: LoWidth]);
            rmsMult = (rmsUpper < -LoPeak) ? -LoPeak : rmsUpper;
            cosMult = effControl.useRms ? rmsMult : loCos;
            sinMult = effControl.useRms ? '0 : loSin;
            prodI = sampleWide * ProductWidth'(cosMult);
            prodQ = sampleWide * ProductWidth'(sinMult);
            // the first sample of a turn reloads the sums
            totalI = (turnStart ? '0 : sumI) + SumWidth'(prodI);
            totalQ = (turnStart ? '0 : sumQ) + SumWidth'(prodQ);
            satI = shiftSaturate(totalI, effControl.sumShift);
            satQ = shiftSaturate(totalQ, effControl.sumShift);
        end

        always_ff @(posedge clk) begin
            sumI <= totalI;
            sumQ <= totalQ;
        end

        assign turnIq[ch].i  = satI[MagWidth-1:0];
        assign turnIq[ch].q  = satQ[MagWidth-1:0];
        assign satFlags[ch]  = satI[MagWidth] | satQ[MagWidth];
    end

    //////////////////////////////////////////////////
    // frame issue under engine credits
    assign issue = turnEnd && (credits != '0);

    always_ff @(posedge clk) begin
        if (turnEnd) begin
            frame.tag <= turnTag;
            frame.iq  <= turnIq;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            turnStart     <= 1'b1;
            activeControl <= '0;
            credits       <= EngineCreditWidth'(EngineCredits);
            turnTag       <= '0;
            frameValid    <= 1'b0;
            dropPulse     <= 1'b0;
            overflowPulse <= 1'b0;
        end else begin
            turnStart <= turnEnd;
            if (turnStart) begin
                activeControl <= control;
            end
            credits <= credits + EngineCreditWidth'(frameCredit)
                     - EngineCreditWidth'(issue);
            frameValid    <= issue;
            // no slot free, the turn is lost but still tagged
            dropPulse     <= turnEnd && !issue;
            overflowPulse <= turnEnd && (|satFlags);
            if (turnEnd) begin
                turnTag <= turnTag + 1'b1;
            end
        end
    end

    // engine never returns more credits than it was given
    creditBound: assert property (@(posedge clk) disable iff (!rstN)
        credits <= EngineCreditWidth'(EngineCredits));

endmodule

// ==== design/loPhase.sv ====
/* LO phase generator
   steps through the cos/sin table one entry per sample and flags turn ends */
module loPhase (
    input  logic                              clk,
    input  logic                              rstN,
    output logic [bpmPkg::PhaseWidth-1:0]     phase,
    output logic signed [bpmPkg::LoWidth-1:0] loCos,
    output logic signed [bpmPkg::LoWidth-1:0] loSin,
    output logic                              turnEnd
);
    import bpmPkg::*;

    // phase 0 lands on the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    assign loCos = LoCosTable[phase];
    assign loSin = LoSinTable[phase];

    // last sample of the turn
    assign turnEnd = (phase == PhaseWidth'(SamplesPerTurn - 1));

endmodule

// ==== design/bpmPkg.sv ====
/* BPM front end shared definitions
   widths, LO tables, enums and the frame and result structs */
package bpmPkg;

    //////////////////////////////////////////////////
    // sizes
    localparam int NumChannels    = 4;
    localparam int AdcWidth       = 16;
    localparam int LoWidth        = 12;
    localparam int ProductWidth   = AdcWidth + LoWidth - 1;
    localparam int SamplesPerTurn = 8;
    localparam int PhaseWidth     = $clog2(SamplesPerTurn);
    localparam int SumWidth       = ProductWidth + 3;
    localparam int MagWidth       = 24;
    localparam int TurnTagWidth   = 8;
    localparam int ChannelWidth   = $clog2(NumChannels);
    localparam int SumShiftWidth  = 4;
    localparam int CfgDataWidth   = 32;
    localparam int DropCountWidth = 8;

    // flow control
    localparam int EngineCredits     = 2;
    localparam int EngineCreditWidth = $clog2(EngineCredits + 1);
    localparam int SlotPtrWidth      = $clog2(EngineCredits);
    localparam int HostCredits       = 4;
    localparam int HostCreditWidth   = $clog2(HostCredits + 1);

    // saturation limits of the signed sums and the magnitude
    localparam logic signed [MagWidth-1:0] MagMax = {1'b0, {(MagWidth - 1){1'b1}}};
    localparam logic signed [MagWidth-1:0] MagMin = {1'b1, {(MagWidth - 1){1'b0}}};

    //////////////////////////////////////////////////
    // local oscillator, one full cycle per turn
    localparam logic signed [LoWidth-1:0] LoPeak = 12'sd2047;

    typedef logic signed [LoWidth-1:0] loTable_t [SamplesPerTurn];

    localparam loTable_t LoCosTable = '{
        12'sd2047, 12'sd1447, 12'sd0, -12'sd1447,
        -12'sd2047, -12'sd1447, 12'sd0, 12'sd1447
    };
    localparam loTable_t LoSinTable = '{
        12'sd0, 12'sd1447, 12'sd2047, 12'sd1447,
        12'sd0, -12'sd1447, -12'sd2047, -12'sd1447
    };

    //////////////////////////////////////////////////
    // enums and structs
    typedef enum logic [1:0] {
        CfgControl   = 2'd0,
        CfgStatus    = 2'd1,
        CfgDropCount = 2'd2
    } cfgAddr_e;

    typedef enum logic {
        Idle  = 1'b0,
        Serve = 1'b1
    } engineState_e;

    typedef struct packed {
        logic signed [MagWidth-1:0] i;
        logic signed [MagWidth-1:0] q;
    } iqPair_t;

    typedef struct packed {
        logic [TurnTagWidth-1:0]      tag;
        iqPair_t [NumChannels-1:0]    iq;
    } sumFrame_t;

    typedef struct packed {
        logic [TurnTagWidth-1:0] tag;
        logic [ChannelWidth-1:0] channel;
        logic [MagWidth-1:0]     mag;
    } magResult_t;

    typedef struct packed {
        logic                     useRms;
        logic [SumShiftWidth-1:0] sumShift;
    } cfgControl_t;

endpackage
